/* design/noc_pkg.sv */
/*
 * Shared types for the 2x2 tile message system
 * Mesh size is fixed at 2x2, single-flit messages only, no virtual channels
 */
`default_nettype none

package noc_pkg;

   // Mesh size is fixed, only the buffer depth is a module parameter
   localparam int NUM_TILES = 4;

   // Ports per router: local, x neighbour, y neighbour
   localparam int NUM_PORTS = 3;

   // Tile number
   // bit 0 is the x coordinate, bit 1 the y coordinate
   typedef logic [1:0] tile_id_t;

   // Message opcodes
   typedef enum logic [1:0] {
      OP_DATA = 2'd0,
      OP_PING = 2'd1,
      OP_PONG = 2'd2
   } msg_op_t;

   // Host send request, the source is stamped by the endpoint
   typedef struct packed {
      tile_id_t    dest;
      msg_op_t     opcode;
      logic [15:0] payload;
   } send_req_t;

   // Single flit on every router and endpoint link
   typedef struct packed {
      tile_id_t    dest;
      tile_id_t    src;
      msg_op_t     opcode;
      logic [15:0] payload;
   } flit_t;

   // Router port index
   // Also the bit or element index of every per-port router array
   typedef enum logic [1:0] {
      PORT_LOCAL = 2'd0,
      PORT_X     = 2'd1,
      PORT_Y     = 2'd2
   } port_t;

endpackage

`default_nettype wire

/* design/flit_buffer.sv */
/*
 * Credit-returning input FIFO, one flit per entry
 * Sender must follow the credit rule, a push into a full buffer is dropped
 */
`default_nettype none

module flit_buffer #(
   parameter int BUF_DEPTH = 4
) (
   input  wire logic           clk,
   input  wire logic           rst_n,
   input  wire logic           push,
   input  wire noc_pkg::flit_t push_flit,
   input  wire logic           pop,
   output logic                head_valid,
   output noc_pkg::flit_t      head_flit,
   output logic                credit
);
   import noc_pkg::*;

   localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int CNT_W = $clog2(BUF_DEPTH + 1);

   flit_t            mem [BUF_DEPTH];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             do_pop;
   logic             do_push;

   assign full       = (count == CNT_W'(BUF_DEPTH));
   assign head_valid = (count != '0);
   assign head_flit  = mem[rd_ptr];

   // Pop only a real entry; push into a full slot only when it drains
   assign do_pop  = pop && head_valid;
   assign do_push = push && (!full || do_pop);

   // One credit back per dequeued flit
   assign credit = do_pop;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap at the depth, not at a power of two
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      end
   end

   // Storage, visible at the head one cycle after the write
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_flit;
      end
   end

endmodule

`default_nettype wire

/* design/noc_router.sv */
/*
 * Three-port mesh router with deterministic XY routing
 * Two cycles per hop at best; outputs drain every cycle, so only credits stall
 * Links to the same port on the neighbour that differs in one coordinate bit
 */
`default_nettype none

module noc_router #(
   parameter int                BUF_DEPTH = 4,
   parameter noc_pkg::tile_id_t TILE_ID   = '0
) (
   input  wire logic                                       clk,
   input  wire logic                                       rst_n,
   // Inputs, indexed by port_t
   input  wire logic [noc_pkg::NUM_PORTS-1:0]              in_valid,
   input  wire noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0]    in_flit,
   output logic [noc_pkg::NUM_PORTS-1:0]                   in_credit_out,
   // Outputs, indexed by port_t
   output logic [noc_pkg::NUM_PORTS-1:0]                   out_valid,
   output noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0]         out_flit,
   input  wire logic [noc_pkg::NUM_PORTS-1:0]              out_credit_in
);
   import noc_pkg::*;

   localparam int PIDX_W = $clog2(NUM_PORTS);
   localparam int CNT_W  = $clog2(BUF_DEPTH + 1);

   logic [NUM_PORTS-1:0]  head_valid;
   flit_t [NUM_PORTS-1:0] head_flit;
   logic [NUM_PORTS-1:0]  buf_pop;
   port_t                 route [NUM_PORTS];
   // req[o][i]: input i wants output o
   logic [NUM_PORTS-1:0]  req [NUM_PORTS];
   logic [NUM_PORTS-1:0]  gnt_vld;
   logic [PIDX_W-1:0]     gnt_idx [NUM_PORTS];
   logic [PIDX_W-1:0]     rr_last [NUM_PORTS];
   logic [NUM_PORTS-1:0]  send;
   logic [CNT_W-1:0]      credit_cnt [NUM_PORTS];

   // XY routing: fix x first, then y, then deliver locally
   function automatic port_t xy_route(tile_id_t dest);
      if (dest[0] != TILE_ID[0]) begin
         return PORT_X;
      end else if (dest[1] != TILE_ID[1]) begin
         return PORT_Y;
      end
      return PORT_LOCAL;
   endfunction

   // Input buffers, one per port
   for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_in
      flit_buffer #(
         .BUF_DEPTH (BUF_DEPTH)
      ) u_buf (
         .clk        (clk),
         .rst_n      (rst_n),
         .push       (in_valid[p]),
         .push_flit  (in_flit[p]),
         .pop        (buf_pop[p]),
         .head_valid (head_valid[p]),
         .head_flit  (head_flit[p]),
         .credit     (in_credit_out[p])
      );

      assign route[p] = xy_route(head_flit[p].dest);
   end

   // Request matrix from the buffer heads
   always_comb begin
      for (int o = 0; o < NUM_PORTS; o++) begin
         for (int i = 0; i < NUM_PORTS; i++) begin
            req[o][i] = head_valid[i] && (route[i] == port_t'(o));
         end
      end
   end

   // Round-robin per output
   // search starts one past the last winner
   always_comb begin
      int idx;
      for (int o = 0; o < NUM_PORTS; o++) begin
         gnt_vld[o] = 1'b0;
         gnt_idx[o] = '0;
         for (int k = 1; k <= NUM_PORTS; k++) begin
            idx = (int'(rr_last[o]) + k) % NUM_PORTS;
            if (!gnt_vld[o] && req[o][idx]) begin
               gnt_vld[o] = 1'b1;
               gnt_idx[o] = PIDX_W'(idx);
            end
         end
         // Output register drains each cycle, so a credit is all it needs
         send[o] = gnt_vld[o] && (credit_cnt[o] != '0);
      end
   end

   // Pop the winners; each input targets one output only
   always_comb begin
      buf_pop = '0;
      for (int o = 0; o < NUM_PORTS; o++) begin
         if (send[o]) begin
            buf_pop[gnt_idx[o]] = 1'b1;
         end
      end
   end

   // Control state per output
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= '0;
         for (int o = 0; o < NUM_PORTS; o++) begin
            credit_cnt[o] <= CNT_W'(BUF_DEPTH);
            // Port 0 wins first after reset
            rr_last[o] <= PIDX_W'(NUM_PORTS - 1);
         end
      end else begin
         out_valid <= send;
         for (int o = 0; o < NUM_PORTS; o++) begin
            // Spend on grant, refill on credit pulse from downstream
            credit_cnt[o] <= credit_cnt[o] - CNT_W'(send[o]) + CNT_W'(out_credit_in[o]);
            if (send[o]) begin
               rr_last[o] <= gnt_idx[o];
            end
         end
      end
   end

   // Output flit registers
   always_ff @(posedge clk) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
         if (send[o]) begin
            out_flit[o] <= head_flit[gnt_idx[o]];
         end
      end
   end

endmodule

`default_nettype wire

/* design/tile_msg_endpoint.sv */
/*
 * Tile message endpoint, host side to local router port
 * PING is answered with PONG and never shown to the host
 * send_ready stays low while a PONG waits; rx port has no back-pressure
 */
`default_nettype none

module tile_msg_endpoint #(
   parameter int                BUF_DEPTH = 4,
   parameter noc_pkg::tile_id_t TILE_ID   = '0
) (
   input  wire logic               clk,
   input  wire logic               rst_n,
   // Host port
   input  wire logic               send_valid,
   output logic                    send_ready,
   input  wire noc_pkg::send_req_t send_req,
   output logic                    rx_valid,
   output noc_pkg::flit_t          rx_flit,
   // Link to the local router port
   input  wire logic               net_in_valid,
   input  wire noc_pkg::flit_t     net_in_flit,
   output logic                    net_credit_out,
   output logic                    net_out_valid,
   output noc_pkg::flit_t          net_out_flit,
   input  wire logic               net_credit_in
);
   import noc_pkg::*;

   localparam int CNT_W = $clog2(BUF_DEPTH + 1);

   logic             head_valid;
   flit_t            head_flit;
   logic             head_is_ping;
   logic             rx_pop;
   logic             tx_valid;
   flit_t            tx_flit;
   logic [CNT_W-1:0] tx_cnt;
   logic             tx_fire;
   logic             pong_valid;
   flit_t            pong_flit;
   logic             pong_load;
   logic             host_take;
   logic             tx_valid_next;
   logic             pong_valid_next;

   // Receive buffer, credits go back to the router
   flit_buffer #(
      .BUF_DEPTH (BUF_DEPTH)
   ) u_rx_buf (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (net_in_valid),
      .push_flit  (net_in_flit),
      .pop        (rx_pop),
      .head_valid (head_valid),
      .head_flit  (head_flit),
      .credit     (net_credit_out)
   );

   assign head_is_ping = (head_flit.opcode == OP_PING);
   // Stall receive while a PONG is still pending
   assign rx_pop = head_valid && !pong_valid;

   // Tx register leaves when a credit is left
   assign tx_fire       = tx_valid && (tx_cnt != '0);
   assign net_out_valid = tx_fire;
   assign net_out_flit  = tx_flit;

   // send_ready already excludes a pending PONG, so these never collide
   assign host_take = send_valid && send_ready;
   assign pong_load = pong_valid && (!tx_valid || tx_fire);

   assign tx_valid_next   = host_take || pong_load || (tx_valid && !tx_fire);
   assign pong_valid_next = (pong_valid && !pong_load) || (rx_pop && head_is_ping);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_valid   <= 1'b0;
         pong_valid <= 1'b0;
         send_ready <= 1'b0;
         rx_valid   <= 1'b0;
         tx_cnt     <= CNT_W'(BUF_DEPTH);
      end else begin
         tx_valid   <= tx_valid_next;
         pong_valid <= pong_valid_next;
         // Registered, equals tx empty and no PONG waiting
         send_ready <= !tx_valid_next && !pong_valid_next;
         // DATA and PONG go to the host, PING is consumed
         rx_valid   <= rx_pop && !head_is_ping;
         tx_cnt     <= tx_cnt - CNT_W'(tx_fire) + CNT_W'(net_credit_in);
      end
   end

   // Payload registers
   always_ff @(posedge clk) begin
      if (host_take) begin
         tx_flit <= '{dest: send_req.dest, src: TILE_ID, opcode: send_req.opcode,
                      payload: send_req.payload};
      end else if (pong_load) begin
         tx_flit <= pong_flit;
      end
      // Reply goes back to the PING sender with the same payload
      if (rx_pop && head_is_ping) begin
         pong_flit <= '{dest: head_flit.src, src: TILE_ID, opcode: OP_PONG,
                        payload: head_flit.payload};
      end
      if (rx_pop) begin
         rx_flit <= head_flit;
      end
   end

endmodule

`default_nettype wire

/* design/system_2x2.sv */
/*
 * 2x2 mesh of routers, one message endpoint per tile
 * Per-tile host ports are indexed by tile id
 */
`default_nettype none

module system_2x2 #(
   parameter int BUF_DEPTH = 4
) (
   input  wire logic                                          clk,
   input  wire logic                                          rst_n,
   input  wire logic [noc_pkg::NUM_TILES-1:0]                 send_valid,
   output logic [noc_pkg::NUM_TILES-1:0]                      send_ready,
   input  wire noc_pkg::send_req_t [noc_pkg::NUM_TILES-1:0]   send_req,
   output logic [noc_pkg::NUM_TILES-1:0]                      rx_valid,
   output noc_pkg::flit_t [noc_pkg::NUM_TILES-1:0]            rx_flit
);
   import noc_pkg::*;

   // Router outputs and credits, per tile and port
   logic [NUM_PORTS-1:0]  rt_out_valid [NUM_TILES];
   flit_t [NUM_PORTS-1:0] rt_out_flit  [NUM_TILES];
   logic [NUM_PORTS-1:0]  rt_in_credit [NUM_TILES];

   // Endpoint side of the local link
   logic [NUM_TILES-1:0]  ep_out_valid;
   flit_t [NUM_TILES-1:0] ep_out_flit;
   logic [NUM_TILES-1:0]  ep_credit;

   for (genvar t = 0; t < NUM_TILES; t++) begin : gen_tile
      // X neighbour is t ^ 1, Y neighbour is t ^ 2
      // concatenation order is PORT_Y, PORT_X, PORT_LOCAL
      noc_router #(
         .BUF_DEPTH (BUF_DEPTH),
         .TILE_ID   (tile_id_t'(t))
      ) u_router (
         .clk           (clk),
         .rst_n         (rst_n),
         .in_valid      ({rt_out_valid[t ^ 2][PORT_Y], rt_out_valid[t ^ 1][PORT_X],
                          ep_out_valid[t]}),
         .in_flit       ({rt_out_flit[t ^ 2][PORT_Y], rt_out_flit[t ^ 1][PORT_X],
                          ep_out_flit[t]}),
         .in_credit_out (rt_in_credit[t]),
         .out_valid     (rt_out_valid[t]),
         .out_flit      (rt_out_flit[t]),
         .out_credit_in ({rt_in_credit[t ^ 2][PORT_Y], rt_in_credit[t ^ 1][PORT_X],
                          ep_credit[t]})
      );

      tile_msg_endpoint #(
         .BUF_DEPTH (BUF_DEPTH),
         .TILE_ID   (tile_id_t'(t))
      ) u_endpoint (
         .clk            (clk),
         .rst_n          (rst_n),
         .send_valid     (send_valid[t]),
         .send_ready     (send_ready[t]),
         .send_req       (send_req[t]),
         .rx_valid       (rx_valid[t]),
         .rx_flit        (rx_flit[t]),
         .net_in_valid   (rt_out_valid[t][PORT_LOCAL]),
         .net_in_flit    (rt_out_flit[t][PORT_LOCAL]),
         .net_credit_out (ep_credit[t]),
         .net_out_valid  (ep_out_valid[t]),
         .net_out_flit   (ep_out_flit[t]),
         .net_credit_in  (rt_in_credit[t][PORT_LOCAL])
      );
   end

endmodule

`default_nettype wire

/* tb/system_2x2_chk.sv */
/*
 * Credit and buffer assertions for one router, bound to every noc_router
 * Shadow counters follow the link traffic seen at the router ports
 */
`default_nettype none

module system_2x2_chk #(
   parameter int BUF_DEPTH = 4
) (
   input wire logic                                clk,
   input wire logic                                rst_n,
   input wire logic [noc_pkg::NUM_PORTS-1:0]       in_valid,
   input wire logic [noc_pkg::NUM_PORTS-1:0]       in_credit_out,
   input wire logic [noc_pkg::NUM_PORTS-1:0]       out_valid,
   input wire logic [noc_pkg::NUM_PORTS-1:0]       out_credit_in,
   input wire logic [$clog2(BUF_DEPTH + 1)-1:0]    credit_cnt [noc_pkg::NUM_PORTS]
);
   import noc_pkg::*;

   localparam int CNT_W = $clog2(BUF_DEPTH + 1);

   // Free slots at the far end of each output
   logic [CNT_W-1:0] link_free [NUM_PORTS];
   // Fill of each input buffer
   logic [CNT_W-1:0] buf_fill  [NUM_PORTS];

   always_ff @(posedge clk) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (!rst_n) begin
            link_free[p] <= CNT_W'(BUF_DEPTH);
            buf_fill[p]  <= '0;
         end else begin
            link_free[p] <= link_free[p] - CNT_W'(out_valid[p]) + CNT_W'(out_credit_in[p]);
            buf_fill[p]  <= buf_fill[p] + CNT_W'(in_valid[p]) - CNT_W'(in_credit_out[p]);
         end
      end
   end

   for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
      // Flit needs a free slot downstream
      assert property (@(posedge clk) disable iff (!rst_n)
                       out_valid[p] |-> link_free[p] != '0)
         else $error("router output %0d sent without a credit", p);

      assert property (@(posedge clk) disable iff (!rst_n)
                       credit_cnt[p] <= CNT_W'(BUF_DEPTH))
         else $error("router output %0d holds more credits than buffer slots", p);

      assert property (@(posedge clk) disable iff (!rst_n)
                       in_valid[p] |-> buf_fill[p] != CNT_W'(BUF_DEPTH))
         else $error("router input %0d pushed while its buffer was full", p);
   end

   // Quiet links right after any reset cycle
   assert property (@(posedge clk) !rst_n |=> (out_valid == '0 && in_credit_out == '0))
      else $error("router link active in the cycle after reset");

endmodule

bind noc_router system_2x2_chk #(
   .BUF_DEPTH (BUF_DEPTH)
) i_router_chk (
   .clk           (clk),
   .rst_n         (rst_n),
   .in_valid      (in_valid),
   .in_credit_out (in_credit_out),
   .out_valid     (out_valid),
   .out_credit_in (out_credit_in),
   .credit_cnt    (credit_cnt)
);

`default_nettype wire

/* tb/tb_system_2x2.sv */
/*
 * Table-driven testbench for the 2x2 message system with BUF_DEPTH 4
 * Scoreboard order is kept per source only
 * Burst rows are injected on their tiles at the same time
 */
`default_nettype none

module tb_system_2x2;
   import noc_pkg::*;

   localparam int BUF_DEPTH   = 4;
   localparam int NUM_ENTRIES = 23;
   localparam int NUM_BURSTS  = 3;
   localparam int BURST_LEN   = 6;
   // Run limit in cycles sized from the table
   localparam int TIMEOUT_CYCLES = 64 * NUM_ENTRIES + 32 * NUM_BURSTS * BURST_LEN + 200;

   // One row of the stimulus table
   // Names are exactly 12 characters
   typedef struct packed {
      logic [8*12-1:0] name;
      tile_id_t        src;
      send_req_t       req;
      logic            burst;
   } entry_t;

   localparam entry_t TESTS [NUM_ENTRIES] = '{
      // Every tile to every tile including itself
      '{"data_t0_to_0", 2'd0, '{2'd0, OP_DATA, 16'hA000}, 1'b0},
      '{"data_t0_to_1", 2'd0, '{2'd1, OP_DATA, 16'hA001}, 1'b0},
      '{"data_t0_to_2", 2'd0, '{2'd2, OP_DATA, 16'hA002}, 1'b0},
      '{"data_t0_to_3", 2'd0, '{2'd3, OP_DATA, 16'hA003}, 1'b0},
      '{"data_t1_to_0", 2'd1, '{2'd0, OP_DATA, 16'hA010}, 1'b0},
      '{"data_t1_to_1", 2'd1, '{2'd1, OP_DATA, 16'hA011}, 1'b0},
      '{"data_t1_to_2", 2'd1, '{2'd2, OP_DATA, 16'hA012}, 1'b0},
      '{"data_t1_to_3", 2'd1, '{2'd3, OP_DATA, 16'hA013}, 1'b0},
      '{"data_t2_to_0", 2'd2, '{2'd0, OP_DATA, 16'hA020}, 1'b0},
      '{"data_t2_to_1", 2'd2, '{2'd1, OP_DATA, 16'hA021}, 1'b0},
      '{"data_t2_to_2", 2'd2, '{2'd2, OP_DATA, 16'hA022}, 1'b0},
      '{"data_t2_to_3", 2'd2, '{2'd3, OP_DATA, 16'hA023}, 1'b0},
      '{"data_t3_to_0", 2'd3, '{2'd0, OP_DATA, 16'hA030}, 1'b0},
      '{"data_t3_to_1", 2'd3, '{2'd1, OP_DATA, 16'hA031}, 1'b0},
      '{"data_t3_to_2", 2'd3, '{2'd2, OP_DATA, 16'hA032}, 1'b0},
      '{"data_t3_to_3", 2'd3, '{2'd3, OP_DATA, 16'hA033}, 1'b0},
      // Diagonal PINGs with two hops each way
      '{"ping_t0_to_3", 2'd0, '{2'd3, OP_PING, 16'hC003}, 1'b0},
      '{"ping_t1_to_2", 2'd1, '{2'd2, OP_PING, 16'hC012}, 1'b0},
      '{"ping_t2_to_1", 2'd2, '{2'd1, OP_PING, 16'hC021}, 1'b0},
      '{"ping_t3_to_0", 2'd3, '{2'd0, OP_PING, 16'hC030}, 1'b0},
      // Three sources into tile 0
      '{"burst_1_to_0", 2'd1, '{2'd0, OP_DATA, 16'hB010}, 1'b1},
      '{"burst_2_to_0", 2'd2, '{2'd0, OP_DATA, 16'hB020}, 1'b1},
      '{"burst_3_to_0", 2'd3, '{2'd0, OP_DATA, 16'hB030}, 1'b1}
   };

   logic                      clk;
   logic                      rst_n;
   logic [NUM_TILES-1:0]      send_valid;
   logic [NUM_TILES-1:0]      send_ready;
   send_req_t [NUM_TILES-1:0] send_req;
   logic [NUM_TILES-1:0]      rx_valid;
   flit_t [NUM_TILES-1:0]     rx_flit;

   // Scoreboard per receiving tile
   // Test names travel alongside
   flit_t     expect_q  [NUM_TILES][$];
   string     name_q    [NUM_TILES][$];
   // Requests not yet taken by the host port
   send_req_t pending_q [NUM_TILES][$];
   int        seed;
   int        cycle_count = 0;
   int        rx_count    = 0;
   int        expected_rx = 0;

   system_2x2 #(
      .BUF_DEPTH (BUF_DEPTH)
   ) i_system_2x2 (
      .clk        (clk),
      .rst_n      (rst_n),
      .send_valid (send_valid),
      .send_ready (send_ready),
      .send_req   (send_req),
      .rx_valid   (rx_valid),
      .rx_flit    (rx_flit)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "testbench stopped at the first error");
   endtask

   function automatic string flit_text(input flit_t f);
      return $sformatf("dest=%0d src=%0d op=%0d payload=%h", f.dest, f.src, f.opcode,
                       f.payload);
   endfunction

   task automatic check_flit(input string name, input flit_t exp, input flit_t act);
      if (act !== exp) begin
         stop_with_failure($sformatf("Fail %s: expected %s, actual %s", name,
                                     flit_text(exp), flit_text(act)));
      end
   endtask

   task automatic check_bits(input string name, input logic [NUM_TILES-1:0] exp,
                             input logic [NUM_TILES-1:0] act);
      if (act !== exp) begin
         stop_with_failure($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         stop_with_failure($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
      end
   endtask

   function automatic logic all_idle();
      for (int t = 0; t < NUM_TILES; t++) begin
         if (expect_q[t].size() != 0 || pending_q[t].size() != 0) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   // Expected flit from the message rules
   // The request itself waits for the host port
   task automatic queue_send(input string name, input tile_id_t src, input send_req_t req);
      flit_t    f;
      tile_id_t rx_tile;
      if (req.opcode == OP_PING) begin
         // PONG comes back from the PING destination
         f       = '{dest: src, src: req.dest, opcode: OP_PONG, payload: req.payload};
         rx_tile = src;
      end else begin
         f       = '{dest: req.dest, src: src, opcode: OP_DATA, payload: req.payload};
         rx_tile = req.dest;
      end
      expect_q[rx_tile].push_back(f);
      name_q[rx_tile].push_back(name);
      expected_rx++;
      pending_q[src].push_back(req);
   endtask

   // All tiles with pending requests send in parallel
   task automatic drive_pending();
      logic busy;
      busy = 1'b1;
      while (busy) begin
         @(negedge clk);
         busy = 1'b0;
         for (int t = 0; t < NUM_TILES; t++) begin
            send_valid[t] = 1'b0;
            if (pending_q[t].size() != 0) begin
               busy = 1'b1;
               // Registered ready means the send is taken at the next rising edge
               if (send_ready[t]) begin
                  send_valid[t] = 1'b1;
                  send_req[t]   = pending_q[t].pop_front();
               end
            end
         end
      end
   endtask

   task automatic wait_idle();
      while (!all_idle()) begin
         @(negedge clk);
      end
   endtask

   // Scoreboard side matches the first expected flit of the same source
   task automatic watch_rx();
      int hit;
      forever begin
         @(negedge clk);
         for (int t = 0; t < NUM_TILES; t++) begin
            if (rst_n && rx_valid[t]) begin
               rx_count++;
               hit = -1;
               for (int k = 0; k < expect_q[t].size(); k++) begin
                  if (hit < 0 && expect_q[t][k].src == rx_flit[t].src) begin
                     hit = k;
                  end
               end
               if (rx_flit[t].opcode == OP_PING) begin
                  stop_with_failure($sformatf("Tile %0d host was shown a PING from tile %0d",
                                              t, rx_flit[t].src));
               end else if (hit < 0) begin
                  stop_with_failure($sformatf("Tile %0d got a flit nobody sent: %s", t,
                                              flit_text(rx_flit[t])));
               end else begin
                  check_flit(name_q[t][hit], expect_q[t][hit], rx_flit[t]);
                  expect_q[t].delete(hit);
                  name_q[t].delete(hit);
               end
            end
         end
      end
   endtask

   // Hang guard
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         stop_with_failure($sformatf("Timeout after %0d cycles, traffic never drained",
                                     cycle_count));
      end
   end

   initial begin
      string     name;
      send_req_t req;
      logic      in_burst;
      seed       = 17;
      in_burst   = 1'b0;
      rst_n      = 1'b0;
      send_valid = '0;
      send_req   = '0;
      repeat (5) begin
         @(negedge clk);
         check_bits("reset_rx_valid", '0, rx_valid);
         check_bits("reset_send_ready", '0, send_ready);
      end
      rst_n = 1'b1;
      // First cycle out of reset
      @(negedge clk);
      check_bits("post_reset_ready", '1, send_ready);
      check_bits("post_reset_rx_valid", '0, rx_valid);
      fork
         watch_rx();
      join_none

      for (int i = 0; i < NUM_ENTRIES; i++) begin
         name = $sformatf("%s", TESTS[i].name);
         // Bursts start on an idle mesh so no PONG mixes with burst DATA
         if (TESTS[i].burst && !in_burst) begin
            wait_idle();
            in_burst = 1'b1;
         end
         queue_send(name, TESTS[i].src, TESTS[i].req);
         if (TESTS[i].burst) begin
            for (int k = 0; k < BURST_LEN; k++) begin
               req         = TESTS[i].req;
               req.payload = 16'($random(seed));
               queue_send($sformatf("%s_%0d", name, k), TESTS[i].src, req);
            end
         end else begin
            drive_pending();
         end
      end
      drive_pending();
      wait_idle();
      // Quiet time so a stray delivery still hits the scoreboard
      repeat (20) @(negedge clk);
      check_count("rx_pulses", expected_rx, rx_count);
      if (all_idle()) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         stop_with_failure("Scoreboard still holds flits at the end of the run");
      end
   end

endmodule

`default_nettype wire

/* compile.f */
design/noc_pkg.sv
design/flit_buffer.sv
design/noc_router.sv
design/tile_msg_endpoint.sv
design/system_2x2.sv
tb/system_2x2_chk.sv
tb/tb_system_2x2.sv

/* run.sh */
#!/bin/sh
# Build and run the 2x2 mesh testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_system_2x2 \
   -f compile.f \
   -o sim_tb_system_2x2

output=$(./obj_dir/sim_tb_system_2x2 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "RESULT: PASS"; then
   exit 0
fi
exit 1
